// File: logic/ccip_copy_pkg.sv
// shared types for the line-copy AFU; lines are 64 bits, single-line requests only, no VCs
`default_nettype none

package ccip_copy_pkg;

   // sizes
   localparam int LINE_W          = 64;  // data bits per line
   localparam int LADDR_W         = 32;  // line address
   localparam int MDATA_W         = 16;  // request tag
   localparam int MMIO_ADDR_W     = 16;  // mmio address, 32-bit word units
   localparam int TID_W           = 9;   // mmio transaction id
   localparam int LEN_W           = 16;  // job length in lines
   localparam int JCNT_W          = 16;  // completed job counter
   localparam int MAX_OUTSTANDING = 8;   // lines read but not yet written

   // derived widths for the credit counter and fifo
   localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);  // holds 0..MAX_OUTSTANDING
   localparam int PTR_W = $clog2(MAX_OUTSTANDING);

   // csr map, word offsets
   localparam logic [MMIO_ADDR_W-1:0] CSR_SRC    = 16'h0;  // source line address
   localparam logic [MMIO_ADDR_W-1:0] CSR_DST    = 16'h2;  // destination line address
   localparam logic [MMIO_ADDR_W-1:0] CSR_LEN    = 16'h4;  // length in lines
   localparam logic [MMIO_ADDR_W-1:0] CSR_CTL    = 16'h6;  // bit 0 write = start
   localparam logic [MMIO_ADDR_W-1:0] CSR_STATUS = 16'h8;  // busy, done, job count

   // opcode of an incoming c0 beat
   typedef enum logic [1:0] {
      RX_NONE,
      RX_RD_RSP,   // read data for an earlier c0 request
      RX_MMIO_WR,
      RX_MMIO_RD
   } t_rx_kind;

   // job fsm
   typedef enum logic [1:0] {
      IDLE,
      RUN,    // reads still going out
      DRAIN,  // all reads out, waiting on write responses
      DONE
   } t_copy_state;

   // c0 tx, line read request
   typedef struct packed {
      logic               valid;
      logic [LADDR_W-1:0] addr;
      logic [MDATA_W-1:0] mdata;  // line offset inside the job
   } t_c0_tx;

   // c1 tx, line write request
   typedef struct packed {
      logic               valid;
      logic [LADDR_W-1:0] addr;
      logic [MDATA_W-1:0] mdata;
      logic [LINE_W-1:0]  data;
   } t_c1_tx;

   // c2 tx, mmio read response
   typedef struct packed {
      logic              valid;
      logic [TID_W-1:0]  tid;   // echoed from the request
      logic [LINE_W-1:0] data;
   } t_c2_tx;

   typedef struct packed {
      t_c0_tx c0;
      t_c1_tx c1;
      t_c2_tx c2;
   } t_if_tx;

   // c0 rx beat, shared by read data and mmio
   typedef struct packed {
      t_rx_kind               kind;
      logic [MDATA_W-1:0]     mdata;      // read rsp only
      logic [TID_W-1:0]       tid;        // mmio only
      logic [MMIO_ADDR_W-1:0] mmio_addr;  // mmio only
      logic [LINE_W-1:0]      data;
   } t_c0_rx;

   typedef struct packed {
      t_c0_rx c0;
      logic   c1_wr_rsp;   // one strobe per c1 write
      logic   c0_almfull;  // no c0 request while high
      logic   c1_almfull;  // no c1 request while high
   } t_if_rx;

   // job parameters, csr block to control
   typedef struct packed {
      logic [LADDR_W-1:0] src;
      logic [LADDR_W-1:0] dst;
      logic [LEN_W-1:0]   len;
   } t_job;

endpackage

`default_nettype wire

// File: logic/mmio_csr.sv
// mmio csr block; only low 32 data bits are used on writes, ctl reads back as zero
`timescale 1ns/1ps
`default_nettype none

module mmio_csr import ccip_copy_pkg::*; (
   input  wire logic        pClk,
   input  wire logic        rst_n,
   input  wire t_c0_rx      rx,      // c0 beat from host
   input  wire logic [31:0] status,  // from copy_ctrl
   output t_job             job,
   output logic             start,   // one-cycle pulse
   output t_c2_tx           c2_tx
);

   logic                  mmio_wr;
   logic                  mmio_rd;
   logic [LADDR_W-1:0]    src_q;
   logic [LADDR_W-1:0]    dst_q;
   logic [LEN_W-1:0]      len_q;
   logic [LINE_W-1:0]     rd_data;  // mux output
   logic                  c2_valid_q;
   logic [TID_W-1:0]      c2_tid_q;
   logic [LINE_W-1:0]     c2_data_q;

   assign mmio_wr = (rx.kind == RX_MMIO_WR);
   assign mmio_rd = (rx.kind == RX_MMIO_RD);

   // start is decoded straight off the beat, copy_ctrl registers it
   assign start = mmio_wr && (rx.mmio_addr == CSR_CTL) && rx.data[0];

   // job registers
   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         src_q <= '0;
         dst_q <= '0;
         len_q <= '0;
      end else if (mmio_wr) begin
         case (rx.mmio_addr)
            CSR_SRC: src_q <= rx.data[LADDR_W-1:0];
            CSR_DST: dst_q <= rx.data[LADDR_W-1:0];
            CSR_LEN: len_q <= rx.data[LEN_W-1:0];
            default: ;  // ctl handled by start decode
         endcase
      end
   end

   assign job = '{src: src_q, dst: dst_q, len: len_q};

   // read mux
   always_comb begin
      case (rx.mmio_addr)
         CSR_SRC:    rd_data = LINE_W'(src_q);
         CSR_DST:    rd_data = LINE_W'(dst_q);
         CSR_LEN:    rd_data = LINE_W'(len_q);
         CSR_STATUS: rd_data = LINE_W'(status);
         default:    rd_data = '0;  // ctl and unmapped offsets
      endcase
   end

   // c2 response one cycle after the request
   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         c2_valid_q <= 1'b0;
      end else begin
         c2_valid_q <= mmio_rd;
      end
   end

   always_ff @(posedge pClk) begin
      if (mmio_rd) begin
         c2_tid_q  <= rx.tid;   // echo tid
         c2_data_q <= rd_data;
      end
   end

   assign c2_tx = '{valid: c2_valid_q, tid: c2_tid_q, data: c2_data_q};

endmodule

`default_nettype wire

// File: logic/copy_ctrl.sv
// job fsm; start is only taken in IDLE or DONE, and the job count wraps at 16 bits
`timescale 1ns/1ps
`default_nettype none

module copy_ctrl import ccip_copy_pkg::*; (
   input  wire logic               pClk,
   input  wire logic               rst_n,
   input  wire logic               start,
   input  wire t_job               job,
   input  wire logic [LEN_W-1:0]   issued,  // reads sent so far
   input  wire logic               wr_rsp,  // one per write completed
   output logic                    run,
   output logic [LADDR_W-1:0]      src,
   output logic [LADDR_W-1:0]      dst,
   output logic [LEN_W-1:0]        len,
   output logic [31:0]             status
);

   t_copy_state        state_q, state_d;
   logic               accept;       // start taken this cycle
   logic [LEN_W-1:0]   rsp_cnt_q;
   logic [LEN_W-1:0]   rsp_cnt_nxt;  // includes this cycle's response
   logic [JCNT_W-1:0]  job_cnt_q;

   assign accept      = start && ((state_q == IDLE) || (state_q == DONE));
   assign rsp_cnt_nxt = rsp_cnt_q + LEN_W'(wr_rsp);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE, DONE: if (start) state_d = RUN;
         RUN:   if (issued == len) state_d = (rsp_cnt_nxt == len) ? DONE : DRAIN;  // len 0 skips drain
         DRAIN: if (rsp_cnt_nxt == len) state_d = DONE;  // done right after last rsp
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         state_q   <= IDLE;
         rsp_cnt_q <= '0;
         job_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (accept) rsp_cnt_q <= '0;
         else        rsp_cnt_q <= rsp_cnt_nxt;
         if ((state_d == DONE) && (state_q != DONE)) job_cnt_q <= job_cnt_q + 1'b1;
      end
   end

   // job latch, only read while busy
   always_ff @(posedge pClk) begin
      if (accept) begin
         src <= job.src;
         dst <= job.dst;
         len <= job.len;
      end
   end

   assign run    = (state_q == RUN);
   assign status = {job_cnt_q, 14'b0,
                    state_q == DONE,                        // done
                    (state_q == RUN) || (state_q == DRAIN)  // busy
                   };

endmodule

`default_nettype wire

// File: logic/rd_req_gen.sv
// c0 read issue; valid is gated by almfull in the same cycle, one line per request
`timescale 1ns/1ps
`default_nettype none

module rd_req_gen import ccip_copy_pkg::*; (
   input  wire logic                pClk,
   input  wire logic                rst_n,
   input  wire logic                run,
   input  wire logic [LADDR_W-1:0]  src,
   input  wire logic [LEN_W-1:0]    len,
   input  wire logic                almfull,   // c0
   input  wire logic                wr_issue,  // frees one credit
   output t_c0_tx                   c0_tx,
   output logic [LEN_W-1:0]         issued
);

   logic              run_q;     // delays issue by one cycle after RUN
   logic [LEN_W-1:0]  issued_q;  // also the next line offset
   logic [CNT_W-1:0]  credit_q;  // lines read, not yet written
   logic              fire;

   assign fire = run_q && !almfull
              && (issued_q < len)
              && (credit_q < CNT_W'(MAX_OUTSTANDING));

   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         run_q    <= 1'b0;
         issued_q <= '0;
         credit_q <= '0;
      end else begin
         run_q <= run;
         if (!run_q)    issued_q <= '0;  // cleared between jobs
         else if (fire) issued_q <= issued_q + 1'b1;
         case ({fire, wr_issue})
            2'b10:   credit_q <= credit_q + 1'b1;
            2'b01:   credit_q <= credit_q - 1'b1;
            default: ;  // both or neither, no change
         endcase
      end
   end

   // tag with offset, the write side rebuilds its address from it
   assign c0_tx = '{valid: fire,
                    addr:  src + LADDR_W'(issued_q),
                    mdata: MDATA_W'(issued_q)};

   assign issued = issued_q;

endmodule

`default_nettype wire

// File: logic/wr_req_gen.sv
// read data buffer and c1 writes; no full check, the read credit keeps the fifo from overflowing
`timescale 1ns/1ps
`default_nettype none

module wr_req_gen import ccip_copy_pkg::*; (
   input  wire logic                pClk,
   input  wire logic                rst_n,
   input  wire t_c0_rx              rx,         // read responses, any order
   input  wire logic [LADDR_W-1:0]  dst,
   input  wire logic                almfull,    // c1
   input  wire logic                wr_rsp_in,  // host write ack
   output t_c1_tx                   c1_tx,
   output logic                     wr_issue,
   output logic                     wr_rsp
);

   typedef struct packed {
      logic [MDATA_W-1:0] mdata;  // line offset
      logic [LINE_W-1:0]  data;
   } t_ent;

   t_ent              mem [MAX_OUTSTANDING];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  cnt_q;     // entries held
   logic              push;
   logic              pop;
   t_ent              head;

   assign push = (rx.kind == RX_RD_RSP);
   assign pop  = (cnt_q != '0) && !almfull;  // head waits out almfull
   assign head = mem[rd_ptr_q];

   // storage, no reset
   always_ff @(posedge pClk) begin
      if (push) mem[wr_ptr_q] <= '{mdata: rx.mdata, data: rx.data};
   end

   always_ff @(posedge pClk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
         if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: ;
         endcase
      end
   end

   // write goes out at the earliest one cycle after its read data
   assign c1_tx = '{valid: pop,
                    addr:  dst + LADDR_W'(head.mdata),
                    mdata: head.mdata,
                    data:  head.data};

   assign wr_issue = pop;        // returns a read credit
   assign wr_rsp   = wr_rsp_in;  // straight to the completion count

endmodule

`default_nettype wire

// File: logic/ccip_copy_afu.sv
// line-copy AFU top; single clock pClk, synchronous rst_n, host port as flat structs
`timescale 1ns/1ps
`default_nettype none

module ccip_copy_afu import ccip_copy_pkg::*; (
   input  wire logic   pClk,
   input  wire logic   rst_n,
   input  wire t_if_rx sRx,   // host to AFU
   output t_if_tx      sTx    // AFU to host
);

   t_job               job;
   logic               start;
   logic [31:0]        status;
   logic               run;
   logic [LADDR_W-1:0] src;
   logic [LADDR_W-1:0] dst;
   logic [LEN_W-1:0]   len;
   logic [LEN_W-1:0]   issued;
   logic               wr_issue;
   logic               wr_rsp;
   t_c0_tx             c0_tx;
   t_c1_tx             c1_tx;
   t_c2_tx             c2_tx;

   mmio_csr mmio_csr_i (
      .pClk   (pClk     ),
      .rst_n  (rst_n    ),
      .rx     (sRx.c0   ),
      .status (status   ),
      .job    (job      ),
      .start  (start    ),
      .c2_tx  (c2_tx    )
   );

   copy_ctrl copy_ctrl_i (
      .pClk   (pClk     ),
      .rst_n  (rst_n    ),
      .start  (start    ),
      .job    (job      ),
      .issued (issued   ),
      .wr_rsp (wr_rsp   ),
      .run    (run      ),
      .src    (src      ),
      .dst    (dst      ),
      .len    (len      ),
      .status (status   )
   );

   rd_req_gen rd_req_gen_i (
      .pClk     (pClk           ),
      .rst_n    (rst_n          ),
      .run      (run            ),
      .src      (src            ),
      .len      (len            ),
      .almfull  (sRx.c0_almfull ),
      .wr_issue (wr_issue       ),
      .c0_tx    (c0_tx          ),
      .issued   (issued         )
   );

   wr_req_gen wr_req_gen_i (
      .pClk      (pClk           ),
      .rst_n     (rst_n          ),
      .rx        (sRx.c0         ),  // shared c0, kind picks read data
      .dst       (dst            ),
      .almfull   (sRx.c1_almfull ),
      .wr_rsp_in (sRx.c1_wr_rsp  ),
      .c1_tx     (c1_tx          ),
      .wr_issue  (wr_issue       ),
      .wr_rsp    (wr_rsp         )
   );

   assign sTx = '{c0: c0_tx, c1: c1_tx, c2: c2_tx};

endmodule

`default_nettype wire

// File: dv/tb_host_mem.sv
// host model; 1024-line memory, read data 0..6 cycles late in random order, writes acked next cycle
`timescale 1ns/1ps
`default_nettype none

module tb_host_mem import ccip_copy_pkg::*; (
   input  wire logic   pClk,
   input  wire logic   rst_n,
   input  wire t_c0_rx mmio,  // testbench beat that wins over read data
   input  wire t_if_tx sTx,
   output t_if_rx      sRx
);

   localparam int MEM_LINES = 1024;

   logic [LINE_W-1:0]  mem [MEM_LINES];
   int                 hits [MEM_LINES];  // writes per line since last clear
   int                 rd_cnt, wr_cnt, rsp_cnt, proto_err, outst, peak;
   logic [LADDR_W-1:0] wr_base;           // dst line of the current job
   integer             seed;
   logic [LADDR_W-1:0] pend_addr [$];
   logic [MDATA_W-1:0] pend_tag [$];
   int                 pend_wait [$];     // cycles left before a read may answer
   t_c0_rx             rsp_q;             // read data beat on offer
   logic               wr_rsp_q, af0_q, af1_q, af1_n;
   int                 af1_run;           // consecutive c1 almfull cycles
   int                 nrdy, pick, sel, i;

   assign sRx = '{c0: (mmio.kind != RX_NONE) ? mmio : rsp_q,
                  c1_wr_rsp: wr_rsp_q, c0_almfull: af0_q, c1_almfull: af1_q};

   task automatic clear_stats(input logic [LADDR_W-1:0] base);
      int k;
      rd_cnt    = 0;
      wr_cnt    = 0;
      rsp_cnt   = 0;
      proto_err = 0;
      outst     = 0;
      peak      = 0;
      wr_base   = base;
      for (k = 0; k < MEM_LINES; k++) hits[k] = 0;
   endtask

   initial begin
      seed     = 65;
      rsp_q    = '0;
      wr_rsp_q = 1'b0;
      af0_q    = 1'b0;
      af1_q    = 1'b0;
      af1_run  = 0;
      for (i = 0; i < MEM_LINES; i++) mem[i] = {$random(seed), 32'(i)};  // low half is the address
      clear_stats('0);
   end

   always @(posedge pClk) begin
      if (!rst_n) begin
         rsp_q    <= '0;
         wr_rsp_q <= 1'b0;
         af0_q    <= 1'b0;
         af1_q    <= 1'b0;
         af1_run  = 0;
      end else begin
         if (sTx.c0.valid) begin
            if (af0_q || (sTx.c0.addr >= MEM_LINES)) proto_err++;  // almfull or out of range
            rd_cnt++;
            outst++;
            pend_addr.push_back(sTx.c0.addr);
            pend_tag.push_back(sTx.c0.mdata);
            pend_wait.push_back($unsigned($random(seed)) % 7);
         end
         if (sTx.c1.valid) begin
            if (af1_q) proto_err++;
            if (sTx.c1.addr != wr_base + LADDR_W'(sTx.c1.mdata)) proto_err++;  // tag is the offset
            if (sTx.c1.addr < MEM_LINES) begin
               mem[sTx.c1.addr] = sTx.c1.data;
               hits[sTx.c1.addr]++;
            end else begin
               proto_err++;
            end
            wr_cnt++;
            outst--;
         end
         if (outst > peak) peak = outst;
         if (wr_rsp_q) rsp_cnt++;
         wr_rsp_q <= sTx.c1.valid;  // one ack per write
         for (i = 0; i < pend_wait.size(); i++) begin
            if (pend_wait[i] > 0) pend_wait[i]--;
         end
         // offered beat is taken unless an mmio beat held c0
         if ((rsp_q.kind != RX_RD_RSP) || (mmio.kind == RX_NONE)) begin
            nrdy = 0;
            for (i = 0; i < pend_wait.size(); i++) begin
               if (pend_wait[i] == 0) nrdy++;
            end
            if (nrdy == 0) begin
               rsp_q <= '0;
            end else begin
               pick = $unsigned($random(seed)) % nrdy;  // any ready entry so order shuffles
               sel  = 0;
               for (i = 0; i < pend_wait.size(); i++) begin
                  if (pend_wait[i] == 0) begin
                     if (pick == 0) sel = i;
                     pick--;
                  end
               end
               rsp_q <= '{kind: RX_RD_RSP, mdata: pend_tag[sel], tid: '0, mmio_addr: '0,
                          data: mem[pend_addr[sel] % MEM_LINES]};
               pend_addr.delete(sel);
               pend_tag.delete(sel);
               pend_wait.delete(sel);
            end
         end
         af0_q   <= (($random(seed) & 7) == 0);  // roughly one cycle in eight
         af1_n   = (af1_run < 31) && (($random(seed) & 7) == 0);
         af1_run = af1_n ? af1_run + 1 : 0;      // c1 almfull capped below 32 cycles
         af1_q   <= af1_n;
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_ccip_copy_afu.sv
// jobs in the golden file must fit in 1024 host lines and must not overlap src with dst
`timescale 1ns/1ps
`default_nettype none

module tb_ccip_copy_afu import ccip_copy_pkg::*; ();

   localparam int NUM_JOBS   = 8;     // rows in the golden file
   localparam int MEM_LINES  = 1024;  // same as the host model
   localparam int POLL_LIMIT = 200;   // status reads before giving up

   logic              pClk;
   logic              rst_n;
   t_if_rx            sRx;
   t_if_tx            sTx;
   t_c0_rx            mmio;                 // mmio beat muxed onto c0 by the host
   logic [31:0]       golden [4*NUM_JOBS];  // src, dst, len, status per job
   logic [LINE_W-1:0] snap [MEM_LINES];     // host memory before the job
   logic [LINE_W-1:0] rdata;
   logic [TID_W-1:0]  next_tid;
   int                src, dst, len, polls, j, a;

   ccip_copy_afu dut_i (.pClk(pClk), .rst_n(rst_n), .sRx(sRx), .sTx(sTx));
   tb_host_mem host_i (.pClk(pClk), .rst_n(rst_n), .mmio(mmio), .sTx(sTx), .sRx(sRx));

   initial begin
      pClk = 1'b0;
      forever #2 pClk = ~pClk;  // 4 ns period
   end

   task automatic abort_run();
      $display("Verification failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic mmio_write(input logic [MMIO_ADDR_W-1:0] addr, input logic [63:0] data);
      @(posedge pClk);
      mmio <= '{kind: RX_MMIO_WR, mdata: '0, tid: '0, mmio_addr: addr, data: data};
      @(posedge pClk);
      mmio <= '0;  // c0 back to the host
   endtask

   // c2 must answer exactly one cycle after the request
   task automatic mmio_read(input logic [MMIO_ADDR_W-1:0] addr, output logic [63:0] data);
      logic [TID_W-1:0] tid;
      tid      = next_tid;
      next_tid = next_tid + 1'b1;
      @(posedge pClk);
      mmio <= '{kind: RX_MMIO_RD, mdata: '0, tid: tid, mmio_addr: addr, data: '0};
      @(negedge pClk);
      check_val("c2.valid in request cycle", sTx.c2.valid, 1'b0);
      @(posedge pClk);
      mmio <= '0;
      @(negedge pClk);
      check_val("c2.valid", sTx.c2.valid, 1'b1);
      check_val("c2.tid", sTx.c2.tid, tid);  // echoed
      data = sTx.c2.data;
   endtask

   initial begin
      next_tid = '0;
      rst_n    = 1'b0;
      mmio     = '0;
      $readmemh("dv/ccip_copy_golden.txt", golden);
      repeat (2) @(posedge pClk);
      rst_n <= 1'b1;
      for (j = 0; j < NUM_JOBS; j++) begin
         src = golden[4*j];
         dst = golden[4*j+1];
         len = golden[4*j+2];
         for (a = 0; a < MEM_LINES; a++) snap[a] = host_i.mem[a];  // expected data source
         host_i.clear_stats(dst);
         mmio_write(CSR_SRC, src);
         mmio_write(CSR_DST, dst);
         mmio_write(CSR_LEN, len);
         mmio_read(CSR_SRC, rdata);
         check_val("csr_src", rdata, src);
         mmio_read(CSR_DST, rdata);
         check_val("csr_dst", rdata, dst);
         mmio_read(CSR_LEN, rdata);
         check_val("csr_len", rdata, len);
         mmio_read(16'ha, rdata);  // unmapped offset
         check_val("csr at 0xa", rdata, 0);
         mmio_write(CSR_CTL, 1);
         if (len != 0) begin
            mmio_write(CSR_CTL, 1);  // lands in RUN and must be dropped
            mmio_read(CSR_STATUS, rdata);
            check_val("status[1:0] while busy", rdata[1:0], 2'b01);
         end
         // poll the done bit every 2 cycles
         polls = 0;
         rdata = '0;
         while (!rdata[1]) begin
            if (polls == POLL_LIMIT) begin
               $display("timeout: job %0d never set the done bit in the status register", j);
               abort_run();
            end else begin
               polls++;
               mmio_read(CSR_STATUS, rdata);
            end
         end
         check_val("status", rdata, golden[4*j+3]);  // done plus job count
         check_val("c0 read requests", host_i.rd_cnt, len);
         check_val("c1 write requests", host_i.wr_cnt, len);
         check_val("c1 write responses", host_i.rsp_cnt, len);
         check_val("host protocol errors", host_i.proto_err, 0);
         check_val("outstanding within limit", host_i.peak <= MAX_OUTSTANDING, 1'b1);
         for (a = 0; a < MEM_LINES; a++) begin
            if ((a >= dst) && (a < dst + len)) begin
               check_val($sformatf("writes to line 0x%0h", a), host_i.hits[a], 1);
               check_val($sformatf("line 0x%0h", a), host_i.mem[a], snap[src + a - dst]);
            end else begin
               check_val($sformatf("writes to line 0x%0h", a), host_i.hits[a], 0);  // stray
            end
         end
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/ccip_copy_golden.txt
// one job per row: src line, dst line, length in lines, expected status after done
// status holds the job count in bits 31:16 and done in bit 1; all lines stay below 0x400
00000010 00000200 00000010 00010002
00000040 00000100 00000001 00020002
00000080 00000300 00000000 00030002
00000000 000003f0 00000010 00040002
00000120 00000020 00000025 00050002
00000200 00000280 00000008 00060002
00000300 00000310 00000003 00070002
000003ff 00000000 00000001 00080002

// File: ccip_copy.f
logic/ccip_copy_pkg.sv
logic/mmio_csr.sv
logic/copy_ctrl.sv
logic/rd_req_gen.sv
logic/wr_req_gen.sv
logic/ccip_copy_afu.sv
dv/tb_host_mem.sv
dv/tb_ccip_copy_afu.sv

// File: Bender.yml
package:
  name: ccip_copy

sources:
  - files:
      - logic/ccip_copy_pkg.sv
      - logic/mmio_csr.sv
      - logic/copy_ctrl.sv
      - logic/rd_req_gen.sv
      - logic/wr_req_gen.sv
      - logic/ccip_copy_afu.sv
  - target: test
    files:
      - dv/tb_host_mem.sv
      - dv/tb_ccip_copy_afu.sv
